// ==== sources.f ====
+incdir+source
source/tcdm_pkg.sv
source/tcdm_mux_ooo.sv
source/tcdm_req_fifo.sv
source/tcdm_mem_target.sv
source/tcdm_ooo_subsystem.sv
sim/tb_tcdm_ooo.sv

// ==== Makefile ====
# Verilator build and run of the tcdm out-of-order testbench
VERILATOR ?= verilator
TOP       ?= tb_tcdm_ooo
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
	  echo "simulation reported an error, see $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "Verification passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_tcdm_ooo.sv ====
// one clock; traffic uses words 0..15, all written before reads; forced ranks must be a permutation
`default_nettype none

`include "tcdm_consts.svh"

module tb_tcdm_ooo
  import tcdm_pkg::*;
();

  localparam int unsigned NB_CHAN    = `TCDM_NB_CHAN;
  localparam int unsigned ADDR_W     = `TCDM_ADDR_W;
  localparam int unsigned DATA_W     = `TCDM_DATA_W;
  localparam int unsigned BE_W       = `TCDM_BE_W;
  localparam int unsigned USED_WORDS = 16;
  // requests per phase, forced priority runs twice
  localparam int unsigned N_DATA  = 200;
  localparam int unsigned N_FAIR  = 80;
  localparam int unsigned N_FORCE = 30;
  localparam int unsigned N_BP    = 24;
  localparam int unsigned HOLD    = 20;
  // about two cycles per request with random r_ready, plus drain slack per phase
  localparam int unsigned PHASE_CYCLES = 10 + HOLD + 8 * 20
    + 2 * (USED_WORDS + N_DATA + N_FAIR + 2 * N_FORCE + N_BP + 2 * NB_CHAN + 1);
  localparam int unsigned TIMEOUT_CYCLES = 4 * PHASE_CYCLES;

  logic                         clk_i;
  logic                         rst_ni           = 1'b0;
  logic                         clear_i          = 1'b0;
  logic                         priority_force_i = 1'b0;
  tcdm_prio_t     [NB_CHAN-1:0] priority_i       = '0;
  logic           [NB_CHAN-1:0] chan_req         = '0;
  tcdm_chan_req_t [NB_CHAN-1:0] chan_req_data    = '0;
  logic           [NB_CHAN-1:0] chan_r_ready     = '0;
  logic           [NB_CHAN-1:0] chan_gnt;
  logic           [NB_CHAN-1:0] chan_r_valid;
  logic           [DATA_W-1:0]  chan_r_data;

  // phase control, written by the sequence
  int unsigned        issue_target = 0;
  logic [NB_CHAN-1:0] chan_en      = '1;
  // full-word writes to consecutive words
  logic               init_mode    = 1'b0;
  logic               ready_hold   = 1'b0;
  logic               fair_check   = 1'b0;

  // stimulus state
  integer             seed       = 32'hb8aa2613;
  int unsigned        issued_cnt = 0;
  int unsigned        init_addr  = 0;
  logic [NB_CHAN-1:0] gnt_seen   = '0;
  int unsigned        cycle_cnt  = 0;

  // reference model and scoreboard
  logic [DATA_W-1:0]  model_mem [`TCDM_MEM_WORDS];
  logic [DATA_W-1:0]  exp_q [NB_CHAN][$];
  int                 fair_hist [$];
  int unsigned        grant_total        = 0;
  int unsigned        grants_since_clear = 0;
  logic               clear_seen         = 1'b0;
  logic               req_seen           = 1'b0;
  logic [NB_CHAN-1:0] hold_q             = '0;
  logic [DATA_W-1:0]  held_data_q        = '0;

  tcdm_ooo_subsystem dut_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .priority_force_i (priority_force_i),
    .priority_i       (priority_i),
    .chan_req         (chan_req),
    .chan_req_data    (chan_req_data),
    .chan_gnt         (chan_gnt),
    .chan_r_valid     (chan_r_valid),
    .chan_r_data      (chan_r_data),
    .chan_r_ready     (chan_r_ready)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_and_stop(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopping at the first error");
  endtask

  // enabled bytes take the write data, the rest keep the old word
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] wdata,
                                                     input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // requesting channel at the lowest rank position, -1 if none
  function automatic int first_ranked(input logic [NB_CHAN-1:0] req,
                                      input tcdm_prio_t [NB_CHAN-1:0] ranks);
    int win;
    win = -1;
    for (int r = 0; r < NB_CHAN; r++) begin
      if (win < 0 && req[ranks[r]]) begin
        win = int'(ranks[r]);
      end
    end
    return win;
  endfunction

  task automatic wait_idle();
    int left;
    do begin
      @(posedge clk_i);
      left = 0;
      for (int k = 0; k < NB_CHAN; k++) begin
        left += exp_q[k].size();
      end
    end while (issued_cnt != issue_target || chan_req != '0 || left != 0);
  endtask

  // protocol properties, sampled on the clock
  gnt_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(chan_gnt))
    else report_and_stop($sformatf("more than one channel granted at time %0t", $time));
  gnt_requested_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                    (chan_gnt & ~chan_req) == '0)
    else report_and_stop($sformatf("grant to a channel without request at time %0t", $time));
  rvalid_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                    $onehot0(chan_r_valid))
    else report_and_stop($sformatf("response valid on several channels at time %0t", $time));

  // a channel issues a new request when idle or just granted
  always @(posedge clk_i) begin : drive_stim
    logic [31:0] rnd;
    int unsigned cnt;
    int unsigned addr_n;
    cnt    = issued_cnt;
    addr_n = init_addr;
    if (rst_ni) begin
      for (int k = 0; k < NB_CHAN; k++) begin
        if (!chan_req[k] || gnt_seen[k]) begin
          if (chan_en[k] && cnt < issue_target) begin
            rnd = $random(seed);
            chan_req[k]                <= 1'b1;
            chan_req_data[k].data      <= $random(seed);
            if (init_mode) begin
              chan_req_data[k].addr    <= ADDR_W'(addr_n);
              chan_req_data[k].wen     <= 1'b0;
              chan_req_data[k].be      <= '1;
              addr_n++;
            end else begin
              chan_req_data[k].addr    <= ADDR_W'(rnd % USED_WORDS);
              // wen high reads
              chan_req_data[k].wen     <= rnd[4];
              chan_req_data[k].be      <= rnd[8 +: BE_W];
            end
            cnt++;
          end else begin
            chan_req[k] <= 1'b0;
          end
        end
      end
      rnd = $random(seed);
      chan_r_ready <= ready_hold ? '0 : rnd[NB_CHAN-1:0];
    end
    issued_cnt <= cnt;
    init_addr  <= addr_n;
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_and_stop($sformatf("timeout, no end of test after %0d cycles", cycle_cnt));
    end
  end

  // mid-cycle, all inputs and outputs are settled
  always @(negedge clk_i) begin : observe
    tcdm_chan_req_t    rq;
    logic [DATA_W-1:0] word;
    int                win;
    int                hits;
    gnt_seen <= chan_gnt;
    if (!rst_ni) begin
      hold_q = '0;
    end else begin
      if (chan_req != '0) begin
        req_seen = 1'b1;
      end
      if (!req_seen) begin
        assert (chan_gnt == '0 && chan_r_valid == '0)
          else report_and_stop("grant or response appeared before any request");
      end
      // rotation history only counts while every channel keeps requesting
      if (!(fair_check && !priority_force_i && chan_req == '1)) begin
        fair_hist.delete();
      end
      for (int k = 0; k < NB_CHAN; k++) begin
        if (chan_gnt[k]) begin
          // grant order is the order the memory applies requests
          rq   = chan_req_data[k];
          word = model_mem[rq.addr];
          if (!rq.wen) begin
            word = merge_bytes(word, rq.data, rq.be);
            model_mem[rq.addr] = word;
          end
          exp_q[k].push_back(word);
          if (priority_force_i) begin
            win = first_ranked(chan_req, priority_i);
            assert (k == win)
              else report_and_stop($sformatf("Mismatch at time %0t: chan_gnt index %0d, expected %0d",
                                             $time, k, win));
          end
          if (clear_seen && grants_since_clear == 0 && !priority_force_i) begin
            assert (k == 0)
              else report_and_stop($sformatf("Mismatch at time %0t: chan_gnt index %0d, expected 0",
                                             $time, k));
          end
          if (fair_check && !priority_force_i && chan_req == '1) begin
            fair_hist.push_back(k);
            if (fair_hist.size() > NB_CHAN) begin
              void'(fair_hist.pop_front());
            end
            // each channel exactly once in any window of NB_CHAN grants
            for (int c = 0; c < NB_CHAN && fair_hist.size() == NB_CHAN; c++) begin
              hits = 0;
              foreach (fair_hist[i]) begin
                if (fair_hist[i] == c) begin
                  hits++;
                end
              end
              assert (hits == 1)
                else report_and_stop($sformatf("channel %0d granted %0d times in %0d grants",
                                               c, hits, NB_CHAN));
            end
          end
          grants_since_clear++;
          grant_total++;
        end
      end
      if (clear_i) begin
        clear_seen         = 1'b1;
        grants_since_clear = 0;
      end
      for (int k = 0; k < NB_CHAN; k++) begin
        // a stalled response must not move
        if (hold_q[k]) begin
          assert (chan_r_valid[k])
            else report_and_stop($sformatf("Mismatch at time %0t: chan_r_valid[%0d] 0, expected 1",
                                           $time, k));
          assert (chan_r_data == held_data_q)
            else report_and_stop($sformatf("Mismatch at time %0t: chan_r_data %h, expected %h",
                                           $time, chan_r_data, held_data_q));
        end
        if (chan_r_valid[k]) begin
          assert (exp_q[k].size() != 0)
            else report_and_stop($sformatf("response on channel %0d with nothing outstanding", k));
          assert (chan_r_data == exp_q[k][0])
            else report_and_stop($sformatf("Mismatch at time %0t: chan_r_data[%0d] %h, expected %h",
                                           $time, k, chan_r_data, exp_q[k][0]));
          if (chan_r_ready[k]) begin
            void'(exp_q[k].pop_front());
          end
        end
      end
      hold_q      = chan_r_valid & ~chan_r_ready;
      held_data_q = chan_r_data;
    end
  end

  initial begin : run_phases
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    // quiet period with no request
    repeat (5) @(posedge clk_i);
    init_mode    <= 1'b1;
    issue_target <= issue_target + USED_WORDS;
    wait_idle();
    // mixed reads and byte-masked writes
    init_mode    <= 1'b0;
    issue_target <= issue_target + N_DATA;
    wait_idle();
    fair_check   <= 1'b1;
    issue_target <= issue_target + N_FAIR;
    wait_idle();
    // fixed ranking 2, 0, 3, 1
    fair_check       <= 1'b0;
    priority_i[0]    <= tcdm_prio_t'(2);
    priority_i[1]    <= tcdm_prio_t'(0);
    priority_i[2]    <= tcdm_prio_t'(3);
    priority_i[3]    <= tcdm_prio_t'(1);
    priority_force_i <= 1'b1;
    issue_target     <= issue_target + N_FORCE;
    wait_idle();
    // top rank silent, lower ranks compete
    chan_en[2]   <= 1'b0;
    issue_target <= issue_target + N_FORCE;
    wait_idle();
    chan_en          <= '1;
    priority_force_i <= 1'b0;
    // back-pressure on every channel until the FIFO is full
    ready_hold   <= 1'b1;
    issue_target <= issue_target + N_BP;
    repeat (HOLD) @(posedge clk_i);
    @(negedge clk_i);
    assert (chan_gnt == '0 && chan_req != '0)
      else report_and_stop("grants still given while every r_ready is held low");
    @(posedge clk_i);
    ready_hold <= 1'b0;
    wait_idle();
    // move the rotation off channel 0 before the clear
    if (grant_total % NB_CHAN == 0) begin
      chan_en      <= '0;
      chan_en[3]   <= 1'b1;
      issue_target <= issue_target + 1;
      wait_idle();
      chan_en      <= '1;
    end
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i      <= 1'b0;
    issue_target <= issue_target + 2 * NB_CHAN;
    wait_idle();
    // trailing window for late or spurious responses
    repeat (5) @(posedge clk_i);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/tcdm_ooo_subsystem.sv ====
// top level, request reaches memory after at least one buffered cycle; no clear on memory
`default_nettype none

`include "tcdm_consts.svh"

module tcdm_ooo_subsystem
  import tcdm_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,

  input  logic                                  priority_force_i,
  input  tcdm_prio_t     [`TCDM_NB_CHAN-1:0]    priority_i,

  input  logic           [`TCDM_NB_CHAN-1:0]    chan_req,
  input  tcdm_chan_req_t [`TCDM_NB_CHAN-1:0]    chan_req_data,
  output logic           [`TCDM_NB_CHAN-1:0]    chan_gnt,
  output logic           [`TCDM_NB_CHAN-1:0]    chan_r_valid,
  output logic           [`TCDM_DATA_W-1:0]     chan_r_data,
  input  logic           [`TCDM_NB_CHAN-1:0]    chan_r_ready
);

  // mux to buffer
  logic      mux_req;
  tcdm_req_t mux_req_data;
  logic      mux_gnt;

  // buffer to memory
  logic      fifo_req;
  tcdm_req_t fifo_req_data;
  logic      fifo_gnt;

  // memory back to mux
  logic      mem_r_valid;
  tcdm_rsp_t mem_r_data;
  logic      mem_r_ready;

  tcdm_mux_ooo mux_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .priority_force_i (priority_force_i),
    .priority_i       (priority_i),
    .chan_req         (chan_req),
    .chan_req_data    (chan_req_data),
    .chan_gnt         (chan_gnt),
    .chan_r_valid     (chan_r_valid),
    .chan_r_data      (chan_r_data),
    .chan_r_ready     (chan_r_ready),
    .mux_req          (mux_req),
    .mux_req_data     (mux_req_data),
    .mux_gnt          (mux_gnt),
    .mem_r_valid      (mem_r_valid),
    .mem_r_data       (mem_r_data),
    .mem_r_ready      (mem_r_ready)
  );

  // id travels through the buffer with the payload
  tcdm_req_fifo fifo_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .in_req   (mux_req),
    .in_data  (mux_req_data),
    .in_gnt   (mux_gnt),
    .out_req  (fifo_req),
    .out_data (fifo_req_data),
    .out_gnt  (fifo_gnt)
  );

  tcdm_mem_target mem_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req      (fifo_req),
    .req_data (fifo_req_data),
    .gnt      (fifo_gnt),
    .r_valid  (mem_r_valid),
    .r_data   (mem_r_data),
    .r_ready  (mem_r_ready)
  );

endmodule

`default_nettype wire

// ==== source/tcdm_mem_target.sv ====
// single-bank word memory, one response per request in arrival order; contents not reset
`default_nettype none

`include "tcdm_consts.svh"

module tcdm_mem_target
  import tcdm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // request side
  input  logic      req,
  input  tcdm_req_t req_data,
  output logic      gnt,

  // response side
  output logic      r_valid,
  output tcdm_rsp_t r_data,
  input  logic      r_ready
);

  localparam int unsigned MEM_WORDS = `TCDM_MEM_WORDS;
  localparam int unsigned DATA_W    = `TCDM_DATA_W;
  localparam int unsigned BE_W      = `TCDM_BE_W;
  localparam int unsigned BYTE_W    = DATA_W / BE_W;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  // held response
  logic              r_valid_q;
  tcdm_rsp_t         rsp_q;

  logic              accept;
  logic              is_write;
  logic [DATA_W-1:0] old_word;
  // addressed word as it will be after this request
  logic [DATA_W-1:0] new_word;

  // free slot, or the held response leaves this cycle
  assign gnt    = ~r_valid_q | r_ready;
  assign accept = req & gnt;

  // wen is active low
  assign is_write = ~req_data.payload.wen;
  assign old_word = mem_q[req_data.payload.addr];

  // byte merge, reads leave the word as it is
  always_comb begin : merge_comb
    new_word = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (is_write && req_data.payload.be[b]) begin
        new_word[b*BYTE_W +: BYTE_W] = req_data.payload.data[b*BYTE_W +: BYTE_W];
      end
    end
  end

  // storage and response payload
  always_ff @(posedge clk_i) begin : data_ff
    if (accept) begin
      if (is_write) begin
        mem_q[req_data.payload.addr] <= new_word;
      end
      rsp_q.data <= new_word;
      // id goes back untouched so the mux can route it
      rsp_q.id   <= req_data.id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_ff
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (accept) begin
      // new response one cycle after the grant
      r_valid_q <= 1'b1;
    end else if (r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  assign r_valid = r_valid_q;
  assign r_data  = rsp_q;

endmodule

`default_nettype wire

// ==== source/tcdm_req_fifo.sv ====
// first-in first-out request buffer, no bypass so a request waits at least one cycle
`default_nettype none

`include "tcdm_consts.svh"

module tcdm_req_fifo
  import tcdm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,

  // write side
  input  logic      in_req,
  input  tcdm_req_t in_data,
  output logic      in_gnt,

  // read side
  output logic      out_req,
  output tcdm_req_t out_data,
  input  logic      out_gnt
);

  localparam int unsigned DEPTH = `TCDM_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // entries hold payload and id untouched
  tcdm_req_t              mem_q [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic                   push;
  logic                   pop;

  assign in_gnt  = (count_q != CNT_W'(DEPTH));
  assign out_req = (count_q != '0);
  // head of queue
  assign out_data = mem_q[rd_ptr_q];

  assign push = in_req & in_gnt;
  assign pop  = out_req & out_gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_ff
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      // drop everything still queued
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      // count only changes when exactly one side moves
      if (push && !pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin : data_ff
    if (push) begin
      mem_q[wr_ptr_q] <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/tcdm_mux_ooo.sv ====
// forced ranks that leave a channel out never grant it; responses must carry the issuing id
`default_nettype none

`include "tcdm_consts.svh"

module tcdm_mux_ooo
  import tcdm_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,

  // external ranking, rank 0 first
  input  logic                                  priority_force_i,
  input  tcdm_prio_t     [`TCDM_NB_CHAN-1:0]    priority_i,

  // channel side
  input  logic           [`TCDM_NB_CHAN-1:0]    chan_req,
  input  tcdm_chan_req_t [`TCDM_NB_CHAN-1:0]    chan_req_data,
  output logic           [`TCDM_NB_CHAN-1:0]    chan_gnt,
  output logic           [`TCDM_NB_CHAN-1:0]    chan_r_valid,
  output logic           [`TCDM_DATA_W-1:0]     chan_r_data,
  input  logic           [`TCDM_NB_CHAN-1:0]    chan_r_ready,

  // request towards the buffer
  output logic                                  mux_req,
  output tcdm_req_t                             mux_req_data,
  input  logic                                  mux_gnt,

  // response from memory
  input  logic                                  mem_r_valid,
  input  tcdm_rsp_t                             mem_r_data,
  output logic                                  mem_r_ready
);

  localparam int unsigned NB_CHAN = `TCDM_NB_CHAN;

  // rotating start point of the ranking
  tcdm_prio_t                 rr_counter_q;
  // channel index at each rank position
  tcdm_prio_t [NB_CHAN-1:0]   rank_list;
  tcdm_prio_t                 winner;
  logic                       winner_valid;
  logic                       mux_accept;

  // counter moves on every transfer into the buffer
  assign mux_accept = mux_req & mux_gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_counter_ff
    if (!rst_ni) begin
      rr_counter_q <= '0;
    end else if (clear_i) begin
      rr_counter_q <= '0;
    end else if (mux_accept) begin
      // wrap explicitly, channel count need not fill the counter range
      if (rr_counter_q == tcdm_prio_t'(NB_CHAN - 1)) begin
        rr_counter_q <= '0;
      end else begin
        rr_counter_q <= rr_counter_q + tcdm_prio_t'(1);
      end
    end
  end

  // rank r names channel (counter + r) mod N unless ranks are forced
  for (genvar r = 0; r < NB_CHAN; r++) begin : gen_rank
    assign rank_list[r] = priority_force_i ? priority_i[r]
                        : tcdm_prio_t'((int'(rr_counter_q) + r) % NB_CHAN);
  end

  // winner takes all: first requesting channel in rank order
  always_comb begin : wta_comb
    winner       = rank_list[0];
    winner_valid = 1'b0;
    for (int r = 0; r < NB_CHAN; r++) begin
      if (!winner_valid && chan_req[rank_list[r]]) begin
        winner       = rank_list[r];
        winner_valid = 1'b1;
      end
    end
  end

  // forward the winning request, id is the channel index
  assign mux_req              = winner_valid;
  assign mux_req_data.payload = chan_req_data[winner];
  assign mux_req_data.id      = winner;

  for (genvar k = 0; k < NB_CHAN; k++) begin : gen_chan
    // only the winner sees the buffer's grant
    assign chan_gnt[k]     = winner_valid & mux_gnt & (winner == tcdm_prio_t'(k));
    // response id selects exactly one channel
    assign chan_r_valid[k] = mem_r_valid & (mem_r_data.id == tcdm_prio_t'(k));
  end

  // data is shared, valid tells who owns it
  assign chan_r_data = mem_r_data.data;

  // back-pressure comes from the channel the response belongs to
  assign mem_r_ready = chan_r_ready[mem_r_data.id];

endmodule

`default_nettype wire

// ==== source/tcdm_pkg.sv ====
// request/response payload types; the wen field keeps the active-low hci meaning
`default_nettype none

`include "tcdm_consts.svh"

package tcdm_pkg;

  // channel index, used both as priority rank entry and as transaction id
  typedef logic [`TCDM_ID_W-1:0] tcdm_prio_t;

  // what a channel presents together with req
  typedef struct packed {
    // word address
    logic [`TCDM_ADDR_W-1:0] addr;
    // active low write enable: 1 reads, 0 writes
    logic                    wen;
    // write data, ignored for reads
    logic [`TCDM_DATA_W-1:0] data;
    // byte enables, only applied on writes
    logic [`TCDM_BE_W-1:0]   be;
  } tcdm_chan_req_t;

  // request after the mux, stamped with the issuing channel
  typedef struct packed {
    tcdm_chan_req_t        payload;
    // index of the channel that issued the request
    logic [`TCDM_ID_W-1:0] id;
  } tcdm_req_t;

  // response from the memory target
  typedef struct packed {
    // addressed word, after the write for write requests
    logic [`TCDM_DATA_W-1:0] data;
    // id reflected unchanged from the request
    logic [`TCDM_ID_W-1:0]   id;
  } tcdm_rsp_t;

endpackage

`default_nettype wire

// ==== source/tcdm_consts.svh ====
// sizing constants; TCDM_NB_CHAN must be a power of two with TCDM_ID_W = log2 of it
`ifndef TCDM_CONSTS_SVH
`define TCDM_CONSTS_SVH

// initiator channels feeding the mux
`define TCDM_NB_CHAN    4
// channel index carried as request/response id
`define TCDM_ID_W       2

// word address, one address per data word
`define TCDM_ADDR_W     8
`define TCDM_DATA_W     32
// one enable per byte of the data word
`define TCDM_BE_W       4

// depth of the memory target, should match 2**TCDM_ADDR_W
`define TCDM_MEM_WORDS  256
// request buffer between mux and memory
`define TCDM_FIFO_DEPTH 4

`endif
